// ==== Makefile ====
SRCS := $(shell grep -v '^+' list.f) hdl/cl_rle_params.svh

.PHONY: run clean

run: obj_dir/Vcl_rle_encoder_tb
	./obj_dir/Vcl_rle_encoder_tb +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Some tests failed" sim.log; then exit 1; fi
	@grep -q "All tests passed" sim.log

obj_dir/Vcl_rle_encoder_tb: $(SRCS) list.f
	verilator --binary --assert -Wno-fatal -f list.f --top-module cl_rle_encoder_tb -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

// ==== hdl/cl_code_output.sv ====
// Result stage of the code-length RLE: registers symbols, sums extra bits and forms hlit and hdist.
`default_nettype none

`include "cl_rle_params.svh"

module cl_code_output (
  input  wire                             clk_gated,
  input  wire                             rst_n,
  input  wire                             sym_val,
  input  wire cl_code_pkg::cl_sym_t       sym,
  input  wire cl_code_pkg::extra_t        extra,
  input  wire cl_code_pkg::extra_len_t    extra_len,
  input  wire                             sym_last,
  input  wire cl_table_pkg::entry_cnt_t   lit_count,
  input  wire cl_table_pkg::entry_cnt_t   dist_count,
  output logic                            out_val,
  output cl_code_pkg::cl_sym_t            out_sym,
  output cl_code_pkg::extra_t             out_extra,
  output cl_code_pkg::extra_len_t         out_extra_len,
  output logic                            out_last,
  output cl_code_pkg::hlit_t              hlit,
  output cl_code_pkg::hdist_t             hdist,
  output cl_code_pkg::extra_total_t       extra_total
);
  import cl_table_pkg::*;
  import cl_code_pkg::*;

  entry_cnt_t    lit_ofs;
  entry_cnt_t    dist_ofs;
  extra_total_t  total_base;
  extra_total_t  total_next;

  assign lit_ofs  = lit_count - entry_cnt_t'(`MIN_LIT_CODES);
  assign dist_ofs = dist_count - entry_cnt_t'(`MIN_DIST_CODES);

  // new table starts counting from zero.
  assign total_base = out_last ? '0 : extra_total;
  assign total_next = sym_val ? total_base + extra_total_t'(extra_len) : total_base;

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_val       <= 1'b0;
      out_last      <= 1'b0;
      out_sym       <= '0;
      out_extra     <= '0;
      out_extra_len <= '0;
      extra_total   <= '0;
      hlit          <= '0;
      hdist         <= '0;
    end
    else
    begin
      out_val     <= sym_val;
      out_last    <= sym_last;
      extra_total <= total_next;
      if (sym_val)
      begin
        out_sym       <= sym;
        out_extra     <= extra;
        out_extra_len <= extra_len;
      end
      // counts are still those of the ending table here.
      if (sym_last)
      begin
        hlit  <= lit_ofs[`HLIT_W-1:0];
        hdist <= dist_ofs[`HDIST_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cl_code_pkg.sv ====
// Types of the output code-length alphabet and the header fields; imported by the encoder stages.
`default_nettype none

`include "cl_rle_params.svh"

package cl_code_pkg;

  // output symbol, literal length 0..15 or repeat code 16..18.
  typedef logic [`CL_SYM_W-1:0] cl_sym_t;

  // extra bits value of a repeat code.
  typedef logic [`CL_EXTRA_W-1:0] extra_t;

  // number of extra bits, 0, 2, 3 or 7.
  typedef logic [`CL_EXTRA_LEN_W-1:0] extra_len_t;

  // sum of extra bits over one table.
  typedef logic [`EXTRA_TOTAL_W-1:0] extra_total_t;

  // header fields.
  typedef logic [`HLIT_W-1:0]  hlit_t;
  typedef logic [`HDIST_W-1:0] hdist_t;

endpackage

`default_nettype wire

// ==== hdl/cl_rle_encoder.sv ====
// Top level of the DEFLATE code-length RLE: connects the run tracker, run coder and output stage.
`default_nettype none

module cl_rle_encoder (
  input  wire                           clk_gated,
  input  wire                           rst_n,
  input  wire                           cl_val,
  input  wire cl_table_pkg::cl_len_t    cl_len,
  input  wire                           cl_dist_start,
  input  wire                           cl_last,
  output logic                          busy,
  output logic                          out_val,
  output cl_code_pkg::cl_sym_t          out_sym,
  output cl_code_pkg::extra_t           out_extra,
  output cl_code_pkg::extra_len_t       out_extra_len,
  output logic                          out_last,
  output cl_code_pkg::hlit_t            hlit,
  output cl_code_pkg::hdist_t           hdist,
  output cl_code_pkg::extra_total_t     extra_total
);
  import cl_table_pkg::*;
  import cl_code_pkg::*;

  // tracker to coder.
  wire             run_val;
  wire cl_len_t    run_len;
  wire run_cnt_t   run_cnt;
  wire             run_last;
  wire             hold;

  // coder to output stage.
  wire             sym_val;
  wire cl_sym_t    sym;
  wire extra_t     extra;
  wire extra_len_t extra_len;
  wire             sym_last;

  // tracker to output stage.
  wire entry_cnt_t lit_count;
  wire entry_cnt_t dist_count;

  cl_run_tracker i_tracker (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .cl_val        (cl_val),
    .cl_len        (cl_len),
    .cl_dist_start (cl_dist_start),
    .cl_last       (cl_last),
    .hold          (hold),
    .busy          (busy),
    .run_val       (run_val),
    .run_len       (run_len),
    .run_cnt       (run_cnt),
    .run_last      (run_last),
    .lit_count     (lit_count),
    .dist_count    (dist_count)
  );

  cl_run_coder i_coder (
    .clk_gated (clk_gated),
    .rst_n     (rst_n),
    .run_val   (run_val),
    .run_len   (run_len),
    .run_cnt   (run_cnt),
    .run_last  (run_last),
    .hold      (hold),
    .sym_val   (sym_val),
    .sym       (sym),
    .extra     (extra),
    .extra_len (extra_len),
    .sym_last  (sym_last)
  );

  cl_code_output i_output (
    .clk_gated     (clk_gated),
    .rst_n         (rst_n),
    .sym_val       (sym_val),
    .sym           (sym),
    .extra         (extra),
    .extra_len     (extra_len),
    .sym_last      (sym_last),
    .lit_count     (lit_count),
    .dist_count    (dist_count),
    .out_val       (out_val),
    .out_sym       (out_sym),
    .out_extra     (out_extra),
    .out_extra_len (out_extra_len),
    .out_last      (out_last),
    .hlit          (hlit),
    .hdist         (hdist),
    .extra_total   (extra_total)
  );

endmodule

`default_nettype wire

// ==== hdl/cl_rle_params.svh ====
// Fixed widths, thresholds and alphabet codes of the code-length RLE; include where needed.
`ifndef CL_RLE_PARAMS_SVH
`define CL_RLE_PARAMS_SVH

// field widths.
`define CL_LEN_W        4
`define CL_SYM_W        5
`define CL_EXTRA_W      7
`define CL_EXTRA_LEN_W  3
`define RUN_CNT_W       8
`define ENTRY_CNT_W     9
`define EXTRA_TOTAL_W   12
`define HLIT_W          5
`define HDIST_W         5

// repeat symbols of the code-length alphabet.
`define SYM_REP_PREV      16
`define SYM_REP_ZR_SHORT  17
`define SYM_REP_ZR_LONG   18

// run thresholds.
`define REP_MIN       3
`define REP_MAX       6
`define ZR_SHORT_MIN  3
`define ZR_LONG_MIN   11
`define ZR_LONG_MAX   138
`define NZ_RUN_MAX    7

// header field offsets.
`define MIN_LIT_CODES   257
`define MIN_DIST_CODES  1

`endif

// ==== hdl/cl_run_coder.sv ====
// Execute stage of the code-length RLE: walks one run record and emits its symbols, one per cycle.
`default_nettype none

`include "cl_rle_params.svh"

module cl_run_coder (
  input  wire                           clk_gated,
  input  wire                           rst_n,
  input  wire                           run_val,
  input  wire cl_table_pkg::cl_len_t    run_len,
  input  wire cl_table_pkg::run_cnt_t   run_cnt,
  input  wire                           run_last,
  output logic                          hold,
  output logic                          sym_val,
  output cl_code_pkg::cl_sym_t          sym,
  output cl_code_pkg::extra_t           extra,
  output cl_code_pkg::extra_len_t       extra_len,
  output logic                          sym_last
);
  import cl_table_pkg::*;
  import cl_code_pkg::*;

  logic [1:0]  step;
  logic [1:0]  last_step;
  logic        zero_run;
  logic        final_sym;
  run_cnt_t    rep_cnt;
  run_cnt_t    cnt_ofs;
  cl_sym_t     lit_sym;

  assign zero_run = (run_len == '0);
  // repeats after the leading literal of a nonzero run.
  assign rep_cnt  = run_cnt - run_cnt_t'(1);
  assign lit_sym  = {1'b0, run_len};

  always_comb
  begin
    last_step = 2'd0;
    sym       = lit_sym;
    cnt_ofs   = '0;
    extra_len = '0;
    if (zero_run)
    begin
      if (run_cnt >= run_cnt_t'(`ZR_LONG_MIN))
      begin
        sym       = cl_sym_t'(`SYM_REP_ZR_LONG);
        cnt_ofs   = run_cnt - run_cnt_t'(`ZR_LONG_MIN);
        extra_len = 3'd7;
      end
      else if (run_cnt >= run_cnt_t'(`ZR_SHORT_MIN))
      begin
        sym       = cl_sym_t'(`SYM_REP_ZR_SHORT);
        cnt_ofs   = run_cnt - run_cnt_t'(`ZR_SHORT_MIN);
        extra_len = 3'd3;
      end
      else
      begin
        // one or two literal zeros.
        last_step = run_cnt[1:0] - 2'd1;
      end
    end
    else if (rep_cnt >= run_cnt_t'(`REP_MIN))
    begin
      // literal first, then one repeat of it.
      last_step = 2'd1;
      if (step != 2'd0)
      begin
        sym       = cl_sym_t'(`SYM_REP_PREV);
        cnt_ofs   = rep_cnt - run_cnt_t'(`REP_MIN);
        extra_len = 3'd2;
      end
    end
    else
    begin
      last_step = rep_cnt[1:0];
    end
  end

  assign extra     = cnt_ofs[`CL_EXTRA_W-1:0];
  assign final_sym = (step == last_step);
  assign hold      = run_val & ~final_sym;
  assign sym_val   = run_val;
  assign sym_last  = run_val & run_last & final_sym;

  // step restarts with each record.
  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      step <= 2'd0;
    end
    else if (run_val)
    begin
      step <= final_sym ? 2'd0 : step + 2'd1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cl_run_tracker.sv ====
// Decode stage of the code-length RLE: takes table entries, groups runs and hands them to the coder.
`default_nettype none

`include "cl_rle_params.svh"

module cl_run_tracker (
  input  wire                           clk_gated,
  input  wire                           rst_n,
  input  wire                           cl_val,
  input  wire cl_table_pkg::cl_len_t    cl_len,
  input  wire                           cl_dist_start,
  input  wire                           cl_last,
  input  wire                           hold,
  output logic                          busy,
  output logic                          run_val,
  output cl_table_pkg::cl_len_t         run_len,
  output cl_table_pkg::run_cnt_t        run_cnt,
  output logic                          run_last,
  output cl_table_pkg::entry_cnt_t      lit_count,
  output cl_table_pkg::entry_cnt_t      dist_count
);
  import cl_table_pkg::*;

  logic      accept;
  logic      close_run;
  logic      flush;
  logic      flush_push;
  logic      push;
  logic      new_table;
  logic      in_dist;
  logic      seg_dist;
  cl_len_t   open_len;
  run_cnt_t  open_cnt;
  run_cnt_t  run_cap;

  // busy only depends on registers, hold comes from the coder step.
  assign busy   = hold | flush;
  assign accept = cl_val & ~busy;

  // zero runs may grow to the long repeat, nonzero ones to a literal plus 6.
  assign run_cap = (open_len == '0) ? run_cnt_t'(`ZR_LONG_MAX) : run_cnt_t'(`NZ_RUN_MAX);

  // no open run before the first entry of a table.
  assign close_run = accept & ~new_table &
                     ((cl_len != open_len) | cl_dist_start | (open_cnt == run_cap));

  assign flush_push = flush & ~hold;
  assign push       = close_run | flush_push;

  // entry belongs to the distance part.
  assign seg_dist = cl_dist_start | (in_dist & ~new_table);

  always_ff @(posedge clk_gated or negedge rst_n)
  begin
    if (!rst_n)
    begin
      flush      <= 1'b0;
      new_table  <= 1'b1;
      in_dist    <= 1'b0;
      lit_count  <= '0;
      dist_count <= '0;
      run_val    <= 1'b0;
      run_last   <= 1'b0;
    end
    else
    begin
      if (accept)
      begin
        flush     <= cl_last;
        new_table <= cl_last;
        in_dist   <= seg_dist;
        if (new_table)
        begin
          lit_count  <= seg_dist ? '0 : entry_cnt_t'(1);
          dist_count <= seg_dist ? entry_cnt_t'(1) : '0;
        end
        else if (seg_dist)
        begin
          dist_count <= dist_count + entry_cnt_t'(1);
        end
        else
        begin
          lit_count <= lit_count + entry_cnt_t'(1);
        end
      end
      else if (flush_push)
      begin
        flush <= 1'b0;
      end

      // record slot frees up on the coder's final symbol.
      if (push)
      begin
        run_val  <= 1'b1;
        run_last <= flush_push;
      end
      else if (!hold)
      begin
        run_val <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_gated)
  begin
    if (push)
    begin
      run_len <= open_len;
      run_cnt <= open_cnt;
    end
    if (accept)
    begin
      open_len <= cl_len;
      open_cnt <= (close_run | new_table) ? run_cnt_t'(1) : open_cnt + run_cnt_t'(1);
    end
  end

endmodule

`default_nettype wire

// ==== hdl/cl_table_pkg.sv ====
// Types of the incoming code-length table and of its runs; imported by the encoder stages.
`default_nettype none

`include "cl_rle_params.svh"

package cl_table_pkg;

  // one table entry, 0 to 15.
  typedef logic [`CL_LEN_W-1:0] cl_len_t;

  // length of a run of equal entries.
  // zero runs reach 138, so 8 bits.
  typedef logic [`RUN_CNT_W-1:0] run_cnt_t;

  // literal or distance entry count of a table.
  typedef logic [`ENTRY_CNT_W-1:0] entry_cnt_t;

endpackage

`default_nettype wire

// ==== list.f ====
+incdir+hdl
hdl/cl_table_pkg.sv
hdl/cl_code_pkg.sv
hdl/cl_run_tracker.sv
hdl/cl_run_coder.sv
hdl/cl_code_output.sv
hdl/cl_rle_encoder.sv
tb/cl_rle_encoder_sva.sv
tb/cl_rle_encoder_tb.sv

// ==== tb/cl_rle_encoder_sva.sv ====
// Concurrent assertions on the encoder's top-level ports; bound to every cl_rle_encoder instance.
`default_nettype none

`include "cl_rle_params.svh"

module cl_rle_encoder_sva (
  input wire                          clk_gated,
  input wire                          rst_n,
  input wire                          busy,
  input wire                          out_val,
  input wire                          out_last,
  input wire cl_code_pkg::cl_sym_t    out_sym,
  input wire cl_code_pkg::extra_len_t out_extra_len
);
  import cl_code_pkg::*;

  int         fail_count = 0;
  extra_len_t want_len;

  // extra-bit count of each repeat code.
  assign want_len = (out_sym == cl_sym_t'(`SYM_REP_PREV))     ? 3'd2 :
                    (out_sym == cl_sym_t'(`SYM_REP_ZR_SHORT)) ? 3'd3 :
                    (out_sym == cl_sym_t'(`SYM_REP_ZR_LONG))  ? 3'd7 : 3'd0;

  last_has_val: assert property (@(posedge clk_gated) disable iff (!rst_n)
                                 out_last |-> out_val)
    else
    begin
      fail_count++;
      $error("out_last without out_val");
    end

  sym_in_range: assert property (@(posedge clk_gated) disable iff (!rst_n)
                                 out_val |-> out_sym <= cl_sym_t'(`SYM_REP_ZR_LONG))
    else
    begin
      fail_count++;
      $error("out_sym above 18");
    end

  extra_len_match: assert property (@(posedge clk_gated) disable iff (!rst_n)
                                    out_val |-> out_extra_len == want_len)
    else
    begin
      fail_count++;
      $error("out_extra_len does not fit out_sym");
    end

  idle_after_reset: assert property (@(posedge clk_gated) $rose(rst_n) |-> !busy)
    else
    begin
      fail_count++;
      $error("busy high right after reset");
    end

endmodule

bind cl_rle_encoder cl_rle_encoder_sva i_sva (
  .clk_gated     (clk_gated),
  .rst_n         (rst_n),
  .busy          (busy),
  .out_val       (out_val),
  .out_last      (out_last),
  .out_sym       (out_sym),
  .out_extra_len (out_extra_len)
);

`default_nettype wire

// ==== tb/cl_rle_encoder_tb.sv ====
// Self-checking testbench of the code-length RLE encoder; compile with list.f, top cl_rle_encoder_tb.
`default_nettype none

`include "cl_rle_params.svh"

module cl_rle_encoder_tb;
  import cl_table_pkg::*;
  import cl_code_pkg::*;

  localparam int NUM_RAND = 24;
  // worst case entries of all tests.
  localparam int TOTAL_ENTRIES = 300 + 10290 + 72 + 22 + NUM_RAND * 318;
  localparam int WATCHDOG_TIME = TOTAL_ENTRIES * 40 + 10000;

  typedef struct packed {
    logic         last;
    cl_sym_t      sym;
    extra_t       extra;
    extra_len_t   elen;
    hlit_t        hlit;
    hdist_t       hdist;
    extra_total_t total;
  } exp_sym_t;

  logic         clk_gated = 1'b0;
  logic         rst_n;
  logic         cl_val;
  logic         cl_dist_start;
  logic         cl_last;
  cl_len_t      cl_len;
  logic         busy;
  logic         out_val;
  logic         out_last;
  cl_sym_t      out_sym;
  extra_t       out_extra;
  extra_len_t   out_extra_len;
  hlit_t        hlit;
  hdist_t       hdist;
  extra_total_t extra_total;

  cl_len_t      tbl [0:511];
  exp_sym_t     exp_q [$];
  exp_sym_t     exp_cur;
  logic [31:0]  lfsr_state;
  int           extra_sum;
  int           err_count;
  int           check_count;

  cl_rle_encoder i_dut (.*);

  always #5 clk_gated = ~clk_gated;

  // galois lfsr, one step per bit.
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++)
    begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
    end
    return v;
  endfunction

  function automatic void push_symbol(input int code, input int extra_val, input int bits);
    exp_sym_t e;
    e       = '0;
    e.sym   = cl_sym_t'(code);
    e.extra = extra_t'(extra_val);
    e.elen  = extra_len_t'(bits);
    exp_q.push_back(e);
    extra_sum = extra_sum + bits;
  endfunction

  function automatic void encode_run(input int v, input int n);
    if (v == 0 && n >= `ZR_LONG_MIN)
      push_symbol(`SYM_REP_ZR_LONG, n - `ZR_LONG_MIN, 7);
    else if (v == 0 && n >= `ZR_SHORT_MIN)
      push_symbol(`SYM_REP_ZR_SHORT, n - `ZR_SHORT_MIN, 3);
    else if (v == 0)
      for (int k = 0; k < n; k++)
        push_symbol(0, 0, 0);
    else
    begin
      // leading literal, then the repeats.
      push_symbol(v, 0, 0);
      if (n - 1 >= `REP_MIN)
        push_symbol(`SYM_REP_PREV, n - 1 - `REP_MIN, 2);
      else
        for (int k = 1; k < n; k++)
          push_symbol(v, 0, 0);
    end
  endfunction

  // reference model of one table, literal part then distance part.
  function automatic void expect_table(input int n_lit, input int n_dist);
    int pos;
    int seg_end;
    int run_n;
    exp_sym_t tail;
    extra_sum = 0;
    for (int seg = 0; seg < 2; seg++)
    begin
      pos     = (seg == 0) ? 0 : n_lit;
      seg_end = (seg == 0) ? n_lit : n_lit + n_dist;
      while (pos < seg_end)
      begin
        run_n = 1;
        while (pos + run_n < seg_end && tbl[pos + run_n] == tbl[pos] &&
               run_n < ((tbl[pos] == '0) ? `ZR_LONG_MAX : `NZ_RUN_MAX))
          run_n++;
        encode_run(int'(tbl[pos]), run_n);
        pos = pos + run_n;
      end
    end
    tail       = exp_q.pop_back();
    tail.last  = 1'b1;
    tail.hlit  = hlit_t'(n_lit - `MIN_LIT_CODES);
    tail.hdist = hdist_t'(n_dist - `MIN_DIST_CODES);
    tail.total = extra_total_t'(extra_sum);
    exp_q.push_back(tail);
  endfunction

  // run of n entries of v between distinct neighbours, then one distance entry.
  function automatic void frame_run(input int n, input cl_len_t v);
    tbl[0] = cl_len_t'(1);
    for (int i = 1; i <= n; i++)
      tbl[i] = v;
    tbl[n + 1] = cl_len_t'(2);
    tbl[n + 2] = cl_len_t'(3);
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
    check_count++;
    if (got !== want)
    begin
      $display("ERROR %0t: %s mismatch, got %0d, expected %0d", $time, what, got, want);
      err_count++;
    end
  endtask

  task automatic send_table(input int n_lit, input int n_dist);
    expect_table(n_lit, n_dist);
    for (int i = 0; i < n_lit + n_dist; i++)
    begin
      @(negedge clk_gated);
      cl_val        = 1'b1;
      cl_len        = tbl[i];
      cl_dist_start = (i == n_lit);
      cl_last       = (i == n_lit + n_dist - 1);
      // held until a cycle with busy low.
      while (busy)
        @(negedge clk_gated);
    end
  endtask

  always @(negedge clk_gated)
  begin
    if (rst_n && out_val)
    begin
      if (exp_q.size() == 0)
      begin
        $display("unexpected symbol %0d at time %0t, none was expected", out_sym, $time);
        err_count++;
      end
      else
      begin
        exp_cur = exp_q.pop_front();
        check_value("sym", 32'(out_sym), 32'(exp_cur.sym));
        check_value("extra", 32'(out_extra), 32'(exp_cur.extra));
        check_value("extra_len", 32'(out_extra_len), 32'(exp_cur.elen));
        check_value("last", 32'(out_last), 32'(exp_cur.last));
        if (exp_cur.last)
        begin
          check_value("hlit", 32'(hlit), 32'(exp_cur.hlit));
          check_value("hdist", 32'(hdist), 32'(exp_cur.hdist));
          check_value("extra_total", 32'(extra_total), 32'(exp_cur.total));
        end
      end
    end
  end

  initial
  begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, the encoder did not finish in time");
    $display("Some tests failed");
    $finish;
  end

  initial
  begin
    int n_lit;
    int n_dist;
    int mode;
    rst_n         = 1'b0;
    cl_val        = 1'b0;
    cl_len        = '0;
    cl_dist_start = 1'b0;
    cl_last       = 1'b0;
    lfsr_state    = 32'h54801613;
    err_count     = 0;
    check_count   = 0;
    repeat (16) @(posedge clk_gated);
    @(negedge clk_gated);
    rst_n = 1'b1;

    // alternating nonzero lengths give literals only.
    for (int i = 0; i < 300; i++)
      tbl[i] = cl_len_t'(1 + i % 15);
    send_table(280, 20);

    for (int n = 1; n <= 140; n++)
    begin
      frame_run(n, cl_len_t'(0));
      send_table(n + 2, 1);
    end
    for (int n = 1; n <= 9; n++)
    begin
      frame_run(n, cl_len_t'(6));
      send_table(n + 2, 1);
    end

    // equal values on both sides of the distance boundary.
    tbl[0] = cl_len_t'(3);
    for (int i = 1; i < 9; i++)
      tbl[i] = cl_len_t'(5);
    tbl[9] = cl_len_t'(2);
    send_table(5, 5);
    tbl[0] = cl_len_t'(1);
    for (int i = 1; i < 12; i++)
      tbl[i] = '0;
    send_table(7, 5);

    for (int t = 0; t < NUM_RAND; t++)
    begin
      n_lit  = `MIN_LIT_CODES + take_bits(5) % 30;
      n_dist = 1 + take_bits(5);
      for (int i = 0; i < n_lit + n_dist; i++)
      begin
        mode = take_bits(3);
        if (mode < 4 && i > 0)
          tbl[i] = tbl[i - 1];
        else if (mode == 4)
          tbl[i] = '0;
        else
          tbl[i] = cl_len_t'(take_bits(4));
      end
      send_table(n_lit, n_dist);
    end

    @(negedge clk_gated);
    cl_val        = 1'b0;
    cl_dist_start = 1'b0;
    cl_last       = 1'b0;
    for (int c = 0; c < 200 && exp_q.size() != 0; c++)
      @(negedge clk_gated);
    repeat (10) @(negedge clk_gated);
    if (exp_q.size() != 0)
    begin
      $display("%0d expected symbols never came out of the encoder", exp_q.size());
      err_count++;
    end
    $display("checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, err_count, i_dut.i_sva.fail_count);
    if (err_count == 0 && i_dut.i_sva.fail_count == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire
